// ==== hw/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Datapath widths
`define CORE_XLEN         32
`define CORE_REG_ADDR_W   5

// Data memory geometry
`define CORE_DMEM_WORDS   256
`define CORE_DMEM_ADDR_W  8    // Word index width, byte address bits 9:2

// RV32I major opcodes kept by this core
`define CORE_OPC_OP       7'b0110011
`define CORE_OPC_OP_IMM   7'b0010011
`define CORE_OPC_LUI      7'b0110111
`define CORE_OPC_LOAD     7'b0000011
`define CORE_OPC_STORE    7'b0100011

// ALU funct3 codes
`define CORE_F3_ADD_SUB   3'b000
`define CORE_F3_SLL       3'b001
`define CORE_F3_SLT       3'b010
`define CORE_F3_SLTU      3'b011
`define CORE_F3_XOR       3'b100
`define CORE_F3_SRL_SRA   3'b101
`define CORE_F3_OR        3'b110
`define CORE_F3_AND       3'b111

// Load/store funct3 codes
`define CORE_F3_B         3'b000
`define CORE_F3_H         3'b001
`define CORE_F3_W         3'b010
`define CORE_F3_BU        3'b100
`define CORE_F3_HU        3'b101

// Operand forward source, youngest producer wins
`define CORE_FWD_NONE     2'd0
`define CORE_FWD_EXE      2'd1
`define CORE_FWD_MEM      2'd2
`define CORE_FWD_WB       2'd3

`endif

// ==== hw/core_pkg.sv ====
`default_nettype none
`include "core_consts.svh"

package core_pkg;

	// R-type layout, also gives opcode/funct3/rs1 for every format
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	// I-type, ALU immediates and loads
	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	// S-type, immediate split around rs2/rs1
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic [19:0] imm;    // Upper 20 bits of result
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	// One instruction word, four ways to look at it
	typedef union packed {
		r_fmt_t r_view;
		i_fmt_t i_view;
		s_fmt_t s_view;
		u_fmt_t u_view;
	} inst_t;

	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		ALU_PASS_B = 4'd10    // LUI, immediate straight through
	} alu_op_t;

	typedef enum logic {
		WB_ALU  = 1'b0,
		WB_LOAD = 1'b1
	} wb_sel_t;

	// Encoded exactly as load/store funct3
	typedef enum logic [2:0] {
		SZ_B  = `CORE_F3_B,
		SZ_H  = `CORE_F3_H,
		SZ_W  = `CORE_F3_W,
		SZ_BU = `CORE_F3_BU,
		SZ_HU = `CORE_F3_HU
	} mem_size_t;

endpackage

`default_nettype wire

// ==== hw/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module inst_decoder (
	input  core_pkg::inst_t             inst,
	output logic [`CORE_REG_ADDR_W-1:0] rs1,
	output logic [`CORE_REG_ADDR_W-1:0] rs2,
	output logic [`CORE_REG_ADDR_W-1:0] rd,
	output logic                        use_rs1,
	output logic                        use_rs2,
	output logic [`CORE_XLEN-1:0]       imm,
	output core_pkg::alu_op_t           alu_op,
	output logic                        use_imm,
	output logic                        reg_wr,
	output logic                        mem_rd,
	output logic                        mem_wr,
	output core_pkg::mem_size_t         size,
	output core_pkg::wb_sel_t           wb_sel
);
	import core_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       alt;    // Instruction bit 30

	assign opcode = inst.r_view.opcode;
	assign funct3 = inst.r_view.funct3;
	assign alt    = inst.r_view.funct7[5];

	// Register fields sit at fixed positions in every format
	assign rs1 = inst.r_view.rs1;
	assign rs2 = inst.s_view.rs2;
	assign rd  = inst.i_view.rd;

	// funct3 to ALU op, SUB only exists in register form
	function automatic alu_op_t op_of(
		input logic [2:0] f3,
		input logic       alt_bit,
		input logic       reg_form
	);
		alu_op_t op;
		case (f3)
			`CORE_F3_ADD_SUB: op = (reg_form && alt_bit) ? ALU_SUB : ALU_ADD;
			`CORE_F3_SLL:     op = ALU_SLL;
			`CORE_F3_SLT:     op = ALU_SLT;
			`CORE_F3_SLTU:    op = ALU_SLTU;
			`CORE_F3_XOR:     op = ALU_XOR;
			`CORE_F3_SRL_SRA: op = alt_bit ? ALU_SRA : ALU_SRL;  // SRAI has imm bit 10 set
			`CORE_F3_OR:      op = ALU_OR;
			default:          op = ALU_AND;
		endcase
		return op;
	endfunction

	always_comb begin
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		imm     = '0;
		alu_op  = ALU_ADD;
		use_imm = 1'b0;
		reg_wr  = 1'b0;
		mem_rd  = 1'b0;
		mem_wr  = 1'b0;
		size    = mem_size_t'(funct3);   // Only meaningful for loads and stores
		wb_sel  = WB_ALU;
		case (opcode)
			`CORE_OPC_OP: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				alu_op  = op_of(funct3, alt, 1'b1);
				reg_wr  = 1'b1;
			end
			`CORE_OPC_OP_IMM: begin
				use_rs1 = 1'b1;
				use_imm = 1'b1;
				imm     = {{20{inst.i_view.imm[11]}}, inst.i_view.imm};
				alu_op  = op_of(funct3, alt, 1'b0);
				reg_wr  = 1'b1;
			end
			`CORE_OPC_LUI: begin
				use_imm = 1'b1;
				imm     = {inst.u_view.imm, 12'h000};
				alu_op  = ALU_PASS_B;
				reg_wr  = 1'b1;
			end
			`CORE_OPC_LOAD: begin
				use_rs1 = 1'b1;
				use_imm = 1'b1;
				imm     = {{20{inst.i_view.imm[11]}}, inst.i_view.imm};  // Address = rs1 + imm
				reg_wr  = 1'b1;
				mem_rd  = 1'b1;
				wb_sel  = WB_LOAD;
			end
			`CORE_OPC_STORE: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;    // Store data
				use_imm = 1'b1;
				imm     = {{20{inst.s_view.imm_hi[6]}}, inst.s_view.imm_hi, inst.s_view.imm_lo};
				mem_wr  = 1'b1;
			end
			default: ;    // Anything else goes down the pipe as a no-op
		endcase
		if (rd == '0)
			reg_wr = 1'b0;    // x0 never retires
	end

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module regfile (
	input  logic                        CLK,
	input  logic                        rst,
	input  logic [`CORE_REG_ADDR_W-1:0] rs1,
	input  logic [`CORE_REG_ADDR_W-1:0] rs2,
	output logic [`CORE_XLEN-1:0]       rd1,
	output logic [`CORE_XLEN-1:0]       rd2,
	input  logic                        wr_en,
	input  logic [`CORE_REG_ADDR_W-1:0] wr_addr,
	input  logic [`CORE_XLEN-1:0]       wr_data
);

	logic [`CORE_XLEN-1:0] regs [32];

	// Write at the end of WB, x0 never touched
	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Async reads see the old value during a same-cycle write
	assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== hw/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module hazard_unit (
	input  logic [`CORE_REG_ADDR_W-1:0] id_rs1,
	input  logic [`CORE_REG_ADDR_W-1:0] id_rs2,
	input  logic                        id_use_rs1,
	input  logic                        id_use_rs2,
	input  logic                        id_valid,
	input  logic [`CORE_REG_ADDR_W-1:0] exe_rd,
	input  logic [`CORE_REG_ADDR_W-1:0] mem_rd_idx,
	input  logic [`CORE_REG_ADDR_W-1:0] wb_rd_idx,
	input  logic                        exe_wr,
	input  logic                        mem_wr_en,
	input  logic                        wb_wr_en,
	input  logic                        exe_is_load,
	output logic [1:0]                  fwd_a,
	output logic [1:0]                  fwd_b,
	output logic                        stall
);

	// Youngest matching producer first
	// Write enables are already cleared for x0, so no x0 check needed here
	function automatic logic [1:0] fwd_src(
		input logic [`CORE_REG_ADDR_W-1:0] rs,
		input logic                        used,
		input logic [`CORE_REG_ADDR_W-1:0] e_rd,
		input logic                        e_wr,
		input logic [`CORE_REG_ADDR_W-1:0] m_rd,
		input logic                        m_wr,
		input logic [`CORE_REG_ADDR_W-1:0] w_rd,
		input logic                        w_wr
	);
		logic [1:0] src;
		src = `CORE_FWD_NONE;
		if (used) begin
			if (e_wr && (e_rd == rs))
				src = `CORE_FWD_EXE;
			else if (m_wr && (m_rd == rs))
				src = `CORE_FWD_MEM;
			else if (w_wr && (w_rd == rs))
				src = `CORE_FWD_WB;    // Covers the regfile read-old-value window
		end
		return src;
	endfunction

	assign fwd_a = fwd_src(id_rs1, id_use_rs1, exe_rd, exe_wr, mem_rd_idx, mem_wr_en,
			wb_rd_idx, wb_wr_en);
	assign fwd_b = fwd_src(id_rs2, id_use_rs2, exe_rd, exe_wr, mem_rd_idx, mem_wr_en,
			wb_rd_idx, wb_wr_en);

	// Load data only exists from MEM on, so an EXE load producer costs one bubble
	assign stall = id_valid && exe_is_load &&
			((fwd_a == `CORE_FWD_EXE) || (fwd_b == `CORE_FWD_EXE));

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module alu (
	input  logic [`CORE_XLEN-1:0] a,
	input  logic [`CORE_XLEN-1:0] b,
	input  core_pkg::alu_op_t     op,
	output logic [`CORE_XLEN-1:0] y
);
	import core_pkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];    // Shift amount from low bits only

	always_comb begin
		case (op)
			ALU_ADD:    y = a + b;
			ALU_SUB:    y = a - b;
			ALU_SLL:    y = a << shamt;
			ALU_SLT:    y = {{(`CORE_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			ALU_SLTU:   y = {{(`CORE_XLEN-1){1'b0}}, a < b};
			ALU_XOR:    y = a ^ b;
			ALU_SRL:    y = a >> shamt;
			ALU_SRA:    y = $unsigned($signed(a) >>> shamt);   // Sign fill
			ALU_OR:     y = a | b;
			ALU_AND:    y = a & b;
			ALU_PASS_B: y = b;
			default:    y = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module data_mem (
	input  logic                  CLK,
	input  logic                  rst,
	input  logic                  wr_en,
	input  logic [`CORE_XLEN-1:0] addr,
	input  logic [`CORE_XLEN-1:0] wr_data,
	input  core_pkg::mem_size_t   wr_size,
	input  logic [1:0]            rd_offset,
	input  core_pkg::mem_size_t   rd_size,
	output logic [`CORE_XLEN-1:0] rd_data
);
	import core_pkg::*;

	// Byte-addressable words, zeroed at start of simulation
	logic [3:0][7:0] mem [`CORE_DMEM_WORDS] = '{default: '0};

	logic [`CORE_DMEM_ADDR_W-1:0] widx;
	logic [3:0]                   be;
	logic [`CORE_XLEN-1:0]        lanes;     // Store data replicated into lanes
	logic [`CORE_XLEN-1:0]        rd_word;   // Registered read, one cycle after addr
	logic [7:0]                   rd_byte;
	logic [15:0]                  rd_half;

	assign widx = addr[`CORE_DMEM_ADDR_W+1:2];    // Upper address bits wrap

	// Store formatting
	always_comb begin
		case (wr_size)
			SZ_B: begin
				be    = 4'b0001 << addr[1:0];
				lanes = {4{wr_data[7:0]}};
			end
			SZ_H: begin
				be    = addr[1] ? 4'b1100 : 4'b0011;
				lanes = {2{wr_data[15:0]}};
			end
			default: begin
				be    = 4'b1111;
				lanes = wr_data;
			end
		endcase
	end

	always_ff @(posedge CLK) begin
		if (wr_en) begin
			for (int i = 0; i < 4; i++)
				if (be[i])
					mem[widx][i] <= lanes[i*8 +: 8];
		end
	end

	// Read before write on the same edge
	always_ff @(posedge CLK) begin
		if (rst)
			rd_word <= '0;
		else
			rd_word <= mem[widx];
	end

	// Load extraction in MEM using the offset of that stage
	assign rd_byte = rd_word[{rd_offset, 3'b000} +: 8];
	assign rd_half = rd_offset[1] ? rd_word[31:16] : rd_word[15:0];

	always_comb begin
		case (rd_size)
			SZ_B:    rd_data = {{24{rd_byte[7]}}, rd_byte};
			SZ_H:    rd_data = {{16{rd_half[15]}}, rd_half};
			SZ_BU:   rd_data = {24'h000000, rd_byte};
			SZ_HU:   rd_data = {16'h0000, rd_half};
			default: rd_data = rd_word;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module core_top (
	input  logic                        CLK,
	input  logic                        rst,
	input  logic                        inst_valid,
	input  logic [`CORE_XLEN-1:0]       inst,
	output logic                        inst_ready,
	output logic                        wb_valid,
	output logic [`CORE_REG_ADDR_W-1:0] wb_rd,
	output logic [`CORE_XLEN-1:0]       wb_data
);
	import core_pkg::*;

	// ID, combinational on the port word
	logic [`CORE_REG_ADDR_W-1:0] id_rs1, id_rs2, id_rd;
	logic                        id_use_rs1, id_use_rs2;
	logic [`CORE_XLEN-1:0]       id_imm;
	alu_op_t                     id_alu_op;
	logic                        id_use_imm, id_reg_wr, id_mem_rd, id_mem_wr;
	mem_size_t                   id_size;
	wb_sel_t                     id_wb_sel;
	logic [`CORE_XLEN-1:0]       id_rf_a, id_rf_b;     // Raw regfile reads
	logic [`CORE_XLEN-1:0]       id_opnd_a, id_opnd_b; // After forwarding
	logic [1:0]                  fwd_a, fwd_b;
	logic                        stall;
	logic                        id_fire;

	// EXE
	logic                        exe_valid;
	logic [`CORE_XLEN-1:0]       exe_a, exe_b, exe_store;
	logic [`CORE_REG_ADDR_W-1:0] exe_rd;
	alu_op_t                     exe_alu_op;
	logic                        exe_reg_wr, exe_mem_rd, exe_mem_wr;
	mem_size_t                   exe_size;
	wb_sel_t                     exe_wb_sel;
	logic [`CORE_XLEN-1:0]       exe_alu_y;
	logic                        exe_wr, exe_is_load, exe_st_en;

	// MEM
	logic                        mem_valid;
	logic [`CORE_XLEN-1:0]       mem_alu_y;
	logic [`CORE_REG_ADDR_W-1:0] mem_rd_idx;
	logic                        mem_reg_wr;
	mem_size_t                   mem_size;
	wb_sel_t                     mem_wb_sel;
	logic [`CORE_XLEN-1:0]       mem_load_data;
	logic [`CORE_XLEN-1:0]       mem_result;    // Writeback value, also forwarded
	logic                        mem_wr_en;

	// WB
	logic                        wb_stage_valid;
	logic [`CORE_REG_ADDR_W-1:0] wb_rd_idx;
	logic                        wb_reg_wr;
	logic [`CORE_XLEN-1:0]       wb_result;
	logic                        wb_wr_en;

	inst_decoder u_dec (
		.inst    (inst),
		.rs1     (id_rs1),
		.rs2     (id_rs2),
		.rd      (id_rd),
		.use_rs1 (id_use_rs1),
		.use_rs2 (id_use_rs2),
		.imm     (id_imm),
		.alu_op  (id_alu_op),
		.use_imm (id_use_imm),
		.reg_wr  (id_reg_wr),
		.mem_rd  (id_mem_rd),
		.mem_wr  (id_mem_wr),
		.size    (id_size),
		.wb_sel  (id_wb_sel)
	);

	regfile u_rf (
		.CLK     (CLK),
		.rst     (rst),
		.rs1     (id_rs1),
		.rs2     (id_rs2),
		.rd1     (id_rf_a),
		.rd2     (id_rf_b),
		.wr_en   (wb_wr_en),
		.wr_addr (wb_rd_idx),
		.wr_data (wb_result)
	);

	hazard_unit u_hzd (
		.id_rs1      (id_rs1),
		.id_rs2      (id_rs2),
		.id_use_rs1  (id_use_rs1),
		.id_use_rs2  (id_use_rs2),
		.id_valid    (inst_valid),
		.exe_rd      (exe_rd),
		.mem_rd_idx  (mem_rd_idx),
		.wb_rd_idx   (wb_rd_idx),
		.exe_wr      (exe_wr),
		.mem_wr_en   (mem_wr_en),
		.wb_wr_en    (wb_wr_en),
		.exe_is_load (exe_is_load),
		.fwd_a       (fwd_a),
		.fwd_b       (fwd_b),
		.stall       (stall)
	);

	assign inst_ready = ~stall;    // Load-use is the only reason to hold the port
	assign id_fire    = inst_valid & inst_ready;

	function automatic logic [`CORE_XLEN-1:0] fwd_pick(
		input logic [1:0]            sel,
		input logic [`CORE_XLEN-1:0] rf_val,
		input logic [`CORE_XLEN-1:0] exe_val,
		input logic [`CORE_XLEN-1:0] mem_val,
		input logic [`CORE_XLEN-1:0] wb_val
	);
		logic [`CORE_XLEN-1:0] val;
		case (sel)
			`CORE_FWD_EXE: val = exe_val;
			`CORE_FWD_MEM: val = mem_val;
			`CORE_FWD_WB:  val = wb_val;
			default:       val = rf_val;
		endcase
		return val;
	endfunction

	assign id_opnd_a = fwd_pick(fwd_a, id_rf_a, exe_alu_y, mem_result, wb_result);
	assign id_opnd_b = fwd_pick(fwd_b, id_rf_b, exe_alu_y, mem_result, wb_result);

	// ID/EXE, bubble when port idle or stalled
	always_ff @(posedge CLK) begin
		if (rst)
			exe_valid <= 1'b0;
		else
			exe_valid <= id_fire;
	end

	always_ff @(posedge CLK) begin
		exe_a      <= id_opnd_a;
		exe_b      <= id_use_imm ? id_imm : id_opnd_b;
		exe_store  <= id_opnd_b;    // rs2 for stores
		exe_rd     <= id_rd;
		exe_alu_op <= id_alu_op;
		exe_reg_wr <= id_reg_wr;
		exe_mem_rd <= id_mem_rd;
		exe_mem_wr <= id_mem_wr;
		exe_size   <= id_size;
		exe_wb_sel <= id_wb_sel;
	end

	alu u_alu (
		.a  (exe_a),
		.b  (exe_b),
		.op (exe_alu_op),
		.y  (exe_alu_y)
	);

	assign exe_wr      = exe_valid & exe_reg_wr;
	assign exe_is_load = exe_valid & exe_mem_rd;
	assign exe_st_en   = exe_valid & exe_mem_wr;

	// Written and addressed from EXE, read data lands in MEM
	data_mem u_dmem (
		.CLK       (CLK),
		.rst       (rst),
		.wr_en     (exe_st_en),
		.addr      (exe_alu_y),
		.wr_data   (exe_store),
		.wr_size   (exe_size),
		.rd_offset (mem_alu_y[1:0]),
		.rd_size   (mem_size),
		.rd_data   (mem_load_data)
	);

	// EXE/MEM
	always_ff @(posedge CLK) begin
		if (rst)
			mem_valid <= 1'b0;
		else
			mem_valid <= exe_valid;
	end

	always_ff @(posedge CLK) begin
		mem_alu_y  <= exe_alu_y;
		mem_rd_idx <= exe_rd;
		mem_reg_wr <= exe_reg_wr;
		mem_size   <= exe_size;
		mem_wb_sel <= exe_wb_sel;
	end

	// Writeback select
	assign mem_result = (mem_wb_sel == WB_LOAD) ? mem_load_data : mem_alu_y;
	assign mem_wr_en  = mem_valid & mem_reg_wr;

	// MEM/WB
	always_ff @(posedge CLK) begin
		if (rst)
			wb_stage_valid <= 1'b0;
		else
			wb_stage_valid <= mem_valid;
	end

	always_ff @(posedge CLK) begin
		wb_rd_idx <= mem_rd_idx;
		wb_reg_wr <= mem_reg_wr;
		wb_result <= mem_result;
	end

	assign wb_wr_en = wb_stage_valid & wb_reg_wr;

	// Retirement port updates on the same edge as the regfile write
	always_ff @(posedge CLK) begin
		if (rst)
			wb_valid <= 1'b0;
		else
			wb_valid <= wb_wr_en;    // Stores, no-ops and x0 never show
	end

	always_ff @(posedge CLK) begin
		wb_rd   <= wb_rd_idx;
		wb_data <= wb_result;
	end

endmodule

`default_nettype wire

// ==== sim/core_checker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module core_checker (
	input  logic        CLK,
	input  logic        rst,
	input  logic        inst_valid,
	input  logic        inst_ready,
	input  logic [31:0] inst,
	input  logic        wb_valid,
	input  logic [4:0]  wb_rd,
	input  logic [31:0] wb_data,
	output int          err_count,
	output int          pending     // Expected retirements still in flight
);

	logic [31:0] regs [32];                              // Architectural registers
	logic [7:0]  mem [1024] = '{default: 8'h00};         // Byte view of data memory
	logic [4:0]  exp_rd [$];
	logic [31:0] exp_data [$];
	int          exp_cyc [$];                            // Edge count at acceptance
	int          cycle;
	logic        prev_load;                              // Load with real rd taken last edge
	logic [4:0]  prev_load_rd;

	// RV32I integer op, alt selects SUB or SRA
	function automatic logic [31:0] alu_model(
		input logic [2:0]  f3,
		input logic        alt,
		input logic [31:0] a,
		input logic [31:0] b
	);
		logic signed [31:0] sa;
		logic [31:0]        r;
		sa = a;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = {31'b0, $signed(a) < $signed(b)};
			3'd3: r = {31'b0, a < b};
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt)
					r = sa >>> b[4:0];    // Sign fill
				else
					r = a >> b[4:0];
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	// Word index from bits 9:2, halfword picked by bit 1 only
	function automatic logic [31:0] load_model(input logic [31:0] addr, input logic [2:0] f3);
		logic [7:0]  b;
		logic [15:0] h;
		logic [31:0] w;
		b = mem[addr[9:0]];
		h = {mem[{addr[9:1], 1'b1}], mem[{addr[9:1], 1'b0}]};
		w = {mem[{addr[9:2], 2'd3}], mem[{addr[9:2], 2'd2}],
			mem[{addr[9:2], 2'd1}], mem[{addr[9:2], 2'd0}]};
		case (f3)
			`CORE_F3_B:  return {{24{b[7]}}, b};
			`CORE_F3_H:  return {{16{h[15]}}, h};
			`CORE_F3_BU: return {24'h0, b};
			`CORE_F3_HU: return {16'h0, h};
			default:     return w;
		endcase
	endfunction

	task automatic store_model(input logic [31:0] addr, input logic [2:0] f3,
			input logic [31:0] data);
		case (f3)
			`CORE_F3_B: mem[addr[9:0]] = data[7:0];
			`CORE_F3_H: begin
				mem[{addr[9:1], 1'b0}] = data[7:0];
				mem[{addr[9:1], 1'b1}] = data[15:8];
			end
			default: begin    // Low address bits ignored for words
				for (int i = 0; i < 4; i++)
					mem[{addr[9:2], 2'(i)}] = data[i*8 +: 8];
			end
		endcase
	endtask

	// Port word reads the register a load one edge ahead is still fetching
	function automatic logic load_use(input logic [31:0] w);
		logic r1, r2;
		r1 = 1'b0;
		r2 = 1'b0;
		case (w[6:0])
			`CORE_OPC_OP, `CORE_OPC_STORE: begin
				r1 = 1'b1;
				r2 = 1'b1;
			end
			`CORE_OPC_OP_IMM, `CORE_OPC_LOAD: r1 = 1'b1;
			default: ;    // LUI and unknown opcodes read nothing
		endcase
		return prev_load && ((r1 && w[19:15] == prev_load_rd) ||
			(r2 && w[24:20] == prev_load_rd));
	endfunction

	// Architectural step for one accepted word
	task automatic model_inst(input logic [31:0] w);
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic [31:0] a, b, i_imm, s_imm, val;
		logic        writes;
		f3     = w[14:12];
		rd     = w[11:7];
		a      = regs[w[19:15]];
		b      = regs[w[24:20]];
		i_imm  = {{20{w[31]}}, w[31:20]};
		s_imm  = {{20{w[31]}}, w[31:25], w[11:7]};
		val    = '0;
		writes = 1'b1;
		case (w[6:0])
			`CORE_OPC_OP:     val = alu_model(f3, w[30], a, b);
			`CORE_OPC_OP_IMM: val = alu_model(f3, (f3 == 3'd5) && w[30], a, i_imm);
			`CORE_OPC_LUI:    val = {w[31:12], 12'h000};
			`CORE_OPC_LOAD:   val = load_model(a + i_imm, f3);
			`CORE_OPC_STORE: begin
				store_model(a + s_imm, f3, b);
				writes = 1'b0;
			end
			default: writes = 1'b0;    // Unknown opcode, no-op
		endcase
		if (writes && rd != 5'd0) begin
			regs[rd] = val;
			exp_rd.push_back(rd);
			exp_data.push_back(val);
			exp_cyc.push_back(cycle);
		end
	endtask

	// Port held back only for a load-use pair
	task automatic check_ready();
		logic exp_ready;
		exp_ready = !(inst_valid && load_use(inst));
		if (inst_ready !== exp_ready) begin
			$display("error at %0t: inst_ready = %b for word %h, expected %b",
				$time, inst_ready, inst, exp_ready);
			err_count++;
		end
	endtask

	task automatic check_retire();
		logic [4:0]  e_rd;
		logic [31:0] e_data;
		int          e_cyc;
		if (exp_rd.size() == 0) begin
			$display("Unexpected retirement at %0t: x%0d = %h with nothing expected",
				$time, wb_rd, wb_data);
			err_count++;
		end else begin
			e_rd   = exp_rd.pop_front();
			e_data = exp_data.pop_front();
			e_cyc  = exp_cyc.pop_front();
			if (wb_rd !== e_rd || wb_data !== e_data) begin
				$display("error at %0t: retired x%0d = %h, expected x%0d = %h",
					$time, wb_rd, wb_data, e_rd, e_data);
				err_count++;
			end
			if (cycle - e_cyc != 4) begin    // Edge N accept, seen on edge N+4
				$display("error at %0t: x%0d seen %0d edges after acceptance, expected 4",
					$time, wb_rd, cycle - e_cyc);
				err_count++;
			end
		end
	endtask

	always @(posedge CLK) begin
		cycle++;
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] = '0;
			exp_rd.delete();
			exp_data.delete();
			exp_cyc.delete();
			err_count = 0;
			prev_load = 1'b0;
		end else begin
			if (wb_valid)
				check_retire();
			check_ready();
			if (inst_valid && inst_ready)
				model_inst(inst);
			prev_load    = inst_valid && inst_ready && inst[6:0] == `CORE_OPC_LOAD &&
				inst[11:7] != 5'd0;
			prev_load_rd = inst[11:7];
		end
		pending = exp_rd.size();
	end

endmodule

`default_nettype wire

// ==== sim/tb_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module tb_core;

	localparam int CLK_HALF_NS     = 20;
	localparam int RESET_CYCLES    = 16;
	localparam int NUM_TESTS       = 5;
	localparam int CYCLES_PER_TEST = 400;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST;

	logic        CLK;
	logic        rst;
	logic        inst_valid;
	logic [31:0] inst;
	logic        inst_ready;
	logic        wb_valid;
	logic [4:0]  wb_rd;
	logic [31:0] wb_data;
	int          err_count, pending;
	int          tb_errs, errs_at_start, pass_count, fail_count;

	core_top DUT (
		.CLK        (CLK),
		.rst        (rst),
		.inst_valid (inst_valid),
		.inst       (inst),
		.inst_ready (inst_ready),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data)
	);

	core_checker u_chk (
		.CLK        (CLK),
		.rst        (rst),
		.inst_valid (inst_valid),
		.inst_ready (inst_ready),
		.inst       (inst),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data),
		.err_count  (err_count),
		.pending    (pending)
	);

	initial begin
		CLK = 1'b0;
		forever #CLK_HALF_NS CLK = ~CLK;
	end

	initial begin
		#(WATCHDOG_CYCLES * 2 * CLK_HALF_NS);
		$display("Timeout: run went past %0d cycles without finishing", WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

	function automatic int unsigned pick(input int unsigned n);
		return $urandom % n;
	endfunction

	// Present a word and hold it until the core takes it
	task automatic send_inst(input logic [31:0] w);
		inst_valid <= 1'b1;
		inst       <= w;
		do @(posedge CLK); while (!inst_ready);
	endtask

	task automatic idle(input int n);
		inst_valid <= 1'b0;
		repeat (n) @(posedge CLK);
	endtask

	task automatic send_reg_op(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [4:0] rs2);
		logic [2:0] f3;
		logic [6:0] f7;
		f3 = 3'(pick(8));
		f7 = ((f3 == `CORE_F3_ADD_SUB || f3 == `CORE_F3_SRL_SRA) && pick(2) == 1) ? 7'h20 : 7'h00;
		send_inst({f7, rs2, rs1, f3, rd, `CORE_OPC_OP});
	endtask

	task automatic send_imm_op(input logic [4:0] rd, input logic [4:0] rs1);
		logic [2:0]  f3;
		logic [11:0] imm;
		f3  = 3'(pick(8));
		imm = 12'($urandom);
		if (f3 == `CORE_F3_SLL)
			imm = {7'h00, imm[4:0]};
		else if (f3 == `CORE_F3_SRL_SRA)
			imm = {(pick(2) == 1) ? 7'h20 : 7'h00, imm[4:0]};    // SRAI or SRLI
		send_inst({imm, rs1, f3, rd, `CORE_OPC_OP_IMM});
	endtask

	task automatic send_lui(input logic [4:0] rd);
		send_inst({20'($urandom), rd, `CORE_OPC_LUI});
	endtask

	// Base x0 or x1 (=64) with offsets 0..95, so regions overlap
	task automatic send_mem_op(input logic use_after);
		logic [2:0]  f3;
		logic [11:0] off;
		logic [4:0]  base, rd;
		off  = 12'(pick(96));
		base = (pick(2) == 1) ? 5'd1 : 5'd0;
		if (pick(2) == 1) begin
			f3 = 3'(pick(3));    // SB, SH, SW
			send_inst({off[11:5], 5'(2 + pick(6)), base, f3, off[4:0], `CORE_OPC_STORE});
		end else begin
			case (pick(5))
				0:       f3 = `CORE_F3_B;
				1:       f3 = `CORE_F3_H;
				2:       f3 = `CORE_F3_W;
				3:       f3 = `CORE_F3_BU;
				default: f3 = `CORE_F3_HU;
			endcase
			rd = 5'(2 + pick(6));
			send_inst({off, base, f3, rd, `CORE_OPC_LOAD});
			if (use_after)
				send_reg_op(5'(2 + pick(6)), rd, 5'(2 + pick(6)));    // Load-use stall
		end
	endtask

	task automatic send_unknown();
		logic [6:0] opc;
		case (pick(6))
			0:       opc = 7'b1100011;    // Branch
			1:       opc = 7'b1101111;    // JAL
			2:       opc = 7'b1100111;    // JALR
			3:       opc = 7'b0010111;    // AUIPC
			4:       opc = 7'b0001111;    // FENCE
			default: opc = 7'b1110011;    // SYSTEM
		endcase
		send_inst({25'($urandom), opc});
	endtask

	// Wait out in-flight retirements, then the fixed tail for strays
	task automatic drain();
		int waited;
		inst_valid <= 1'b0;
		waited = 0;
		do begin
			@(negedge CLK);
			waited++;
		end while (pending != 0 && waited < 16);
		repeat (4) @(negedge CLK);
		if (pending != 0) begin
			$display("%0d expected retirements never arrived", pending);
			tb_errs++;
		end
		@(posedge CLK);
	endtask

	task automatic finish_test(input int num, input string name);
		int errs_now;
		drain();
		errs_now = err_count + tb_errs;
		if (errs_now == errs_at_start) begin
			$display("test %0d %s: pass", num, name);
			pass_count++;
		end else begin
			$display("test %0d %s: FAIL, %0d new errors", num, name, errs_now - errs_at_start);
			fail_count++;
		end
		errs_at_start = errs_now;
	endtask

	initial begin
		logic [4:0] rd, p1, p2, p3;
		rst        <= 1'b1;
		inst_valid <= 1'b0;
		inst       <= '0;
		void'($urandom(32'ha959_4507));
		repeat (RESET_CYCLES) @(posedge CLK);
		rst <= 1'b0;
		@(posedge CLK);

		// Seed x1..x7 with nonzero values first
		for (int r = 1; r < 8; r++) begin
			send_lui(5'(r));
			send_inst({12'($urandom), 5'(r), `CORE_F3_ADD_SUB, 5'(r), `CORE_OPC_OP_IMM});
		end
		repeat (40) send_reg_op(5'(pick(8)), 5'(pick(8)), 5'(pick(8)));
		finish_test(1, "register ALU ops");

		repeat (40) begin
			if (pick(4) == 0)
				send_lui(5'(pick(8)));
			else
				send_imm_op(5'(pick(8)), 5'(pick(8)));
		end
		finish_test(2, "immediate ops and LUI");

		// Each op reads the last one or two results
		p1 = 5'd1;
		p2 = 5'd2;
		p3 = 5'd3;
		repeat (50) begin
			rd = 5'(1 + pick(7));
			if (pick(2) == 1)
				send_reg_op(rd, p1, (pick(2) == 1) ? p2 : p3);
			else
				send_imm_op(rd, p1);
			p3 = p2;
			p2 = p1;
			p1 = rd;
		end
		finish_test(3, "dependent chains");

		send_inst({12'd64, 5'd0, `CORE_F3_ADD_SUB, 5'd1, `CORE_OPC_OP_IMM});    // x1 = 64
		repeat (60) begin
			if (pick(4) == 0)
				send_imm_op(5'(2 + pick(6)), 5'(2 + pick(6)));    // Fresh store data
			send_mem_op(pick(2) == 1);
		end
		finish_test(4, "loads and stores");

		repeat (60) begin
			if (pick(3) == 0)
				idle(1 + pick(3));
			case (pick(5))
				0:       send_reg_op(5'(pick(8)), 5'(pick(8)), 5'(pick(8)));
				1:       send_imm_op(5'(pick(8)), 5'(pick(8)));
				2:       send_lui(5'(pick(8)));
				3:       send_mem_op(pick(2) == 1);
				default: send_unknown();
			endcase
		end
		finish_test(5, "gaps and unknown opcodes");

		$display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count,
			err_count + tb_errs);
		if (fail_count == 0 && err_count + tb_errs == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hw
hw/core_pkg.sv
hw/inst_decoder.sv
hw/regfile.sv
hw/hazard_unit.sv
hw/alu.sv
hw/data_mem.sv
hw/core_top.sv
sim/core_checker.sv
sim/tb_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_core -f all.f -o tb_core_sim
./obj_dir/tb_core_sim > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation passed"
